//--- verilog/rv_ctl_pkg.sv
package rv_ctl_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // Decoded instruction class, NOP also covers FENCE and SYSTEM
    typedef enum logic [3:0] {
        CLS_LUI    = 4'd0,
        CLS_AUIPC  = 4'd1,
        CLS_JAL    = 4'd2,
        CLS_JALR   = 4'd3,
        CLS_BRANCH = 4'd4,
        CLS_LOAD   = 4'd5,
        CLS_STORE  = 4'd6,
        CLS_OP_IMM = 4'd7,
        CLS_OP     = 4'd8,
        CLS_NOP    = 4'd9
    } instr_class_e;

    // ALU operation codes as the datapath expects them
    typedef enum logic [3:0] {
        ALU_AND    = 4'b0000,
        ALU_OR     = 4'b0001,
        ALU_XOR    = 4'b0010,
        ALU_ADD    = 4'b0011,
        ALU_SUB    = 4'b0100,
        ALU_PASS_B = 4'b0110,
        ALU_SLL    = 4'b0111,
        ALU_SRL    = 4'b1000,
        ALU_SRA    = 4'b1010,
        ALU_SLTU   = 4'b1011,
        ALU_SLT    = 4'b1100
    } alu_op_e;

    typedef enum logic [3:0] {
        IMM_R = 4'd0,
        IMM_I = 4'd1,
        IMM_S = 4'd2,
        IMM_B = 4'd3,
        IMM_U = 4'd4,
        IMM_J = 4'd5
    } imm_sel_e;

    typedef enum logic [1:0] {
        WB_MEM = 2'd0,
        WB_ALU = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // RV32I major opcodes
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_FENCE  = 7'b0001111;
    localparam opcode_t OPC_SYSTEM = 7'b1110011;

    // Branch conditions
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // OP and OP-IMM groups
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

endpackage

//--- verilog/format_decode.sv
`timescale 1ns/10ps

module format_decode (
    input  rv_ctl_pkg::opcode_t      opcode,
    output rv_ctl_pkg::instr_class_e instr_class,
    output logic                     a_sel,
    output logic                     b_sel,
    output rv_ctl_pkg::imm_sel_e     imm_sel,
    output logic                     mem_wr,
    output logic                     reg_wen,
    output rv_ctl_pkg::wb_sel_e      wb_sel
);

    // Opcode to class
    always_comb begin
        case (opcode)
            rv_ctl_pkg::OPC_LUI:    instr_class = rv_ctl_pkg::CLS_LUI;
            rv_ctl_pkg::OPC_AUIPC:  instr_class = rv_ctl_pkg::CLS_AUIPC;
            rv_ctl_pkg::OPC_JAL:    instr_class = rv_ctl_pkg::CLS_JAL;
            rv_ctl_pkg::OPC_JALR:   instr_class = rv_ctl_pkg::CLS_JALR;
            rv_ctl_pkg::OPC_BRANCH: instr_class = rv_ctl_pkg::CLS_BRANCH;
            rv_ctl_pkg::OPC_LOAD:   instr_class = rv_ctl_pkg::CLS_LOAD;
            rv_ctl_pkg::OPC_STORE:  instr_class = rv_ctl_pkg::CLS_STORE;
            rv_ctl_pkg::OPC_OP_IMM: instr_class = rv_ctl_pkg::CLS_OP_IMM;
            rv_ctl_pkg::OPC_OP:     instr_class = rv_ctl_pkg::CLS_OP;
            // FENCE, ECALL and EBREAK do nothing here
            rv_ctl_pkg::OPC_FENCE:  instr_class = rv_ctl_pkg::CLS_NOP;
            rv_ctl_pkg::OPC_SYSTEM: instr_class = rv_ctl_pkg::CLS_NOP;
            default:                instr_class = rv_ctl_pkg::CLS_NOP;
        endcase
    end

    // Per-class datapath controls, NOP values by default
    always_comb begin
        a_sel   = 1'b0;
        b_sel   = 1'b0;
        imm_sel = rv_ctl_pkg::IMM_R;
        mem_wr  = 1'b0;
        reg_wen = 1'b0;
        wb_sel  = rv_ctl_pkg::WB_MEM;

        case (instr_class)
            rv_ctl_pkg::CLS_LUI: begin
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_U;
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_ALU;
            end
            rv_ctl_pkg::CLS_AUIPC: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_U;
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_ALU;
            end
            rv_ctl_pkg::CLS_JAL: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_J;
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_PC4;
            end
            rv_ctl_pkg::CLS_JALR: begin
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_I;
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_PC4;
            end
            // Target is PC plus immediate
            rv_ctl_pkg::CLS_BRANCH: begin
                a_sel   = 1'b1;
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_B;
            end
            rv_ctl_pkg::CLS_LOAD: begin
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_I;
                reg_wen = 1'b1;
            end
            rv_ctl_pkg::CLS_STORE: begin
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_S;
                mem_wr  = 1'b1;
            end
            rv_ctl_pkg::CLS_OP_IMM: begin
                b_sel   = 1'b1;
                imm_sel = rv_ctl_pkg::IMM_I;
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_ALU;
            end
            rv_ctl_pkg::CLS_OP: begin
                reg_wen = 1'b1;
                wb_sel  = rv_ctl_pkg::WB_ALU;
            end
            default: begin
                a_sel = 1'b0;
            end
        endcase

        // A store never writes the register file
        assert (!(mem_wr && reg_wen))
            else $error("mem_wr and reg_wen both set for opcode %b", opcode);
    end

endmodule

//--- verilog/alu_op_decode.sv
`timescale 1ns/10ps

module alu_op_decode (
    input  rv_ctl_pkg::instr_class_e instr_class,
    input  rv_ctl_pkg::funct3_t      funct3,
    input  logic                     funct7_b5,
    output rv_ctl_pkg::alu_op_e      alu_sel
);

    logic is_op;

    // SUB exists only in the register form
    assign is_op = (instr_class == rv_ctl_pkg::CLS_OP);

    always_comb begin
        case (instr_class)
            rv_ctl_pkg::CLS_LUI:    alu_sel = rv_ctl_pkg::ALU_PASS_B;
            rv_ctl_pkg::CLS_AUIPC,
            rv_ctl_pkg::CLS_JAL,
            rv_ctl_pkg::CLS_JALR,
            rv_ctl_pkg::CLS_BRANCH,
            rv_ctl_pkg::CLS_LOAD,
            rv_ctl_pkg::CLS_STORE:  alu_sel = rv_ctl_pkg::ALU_ADD;
            rv_ctl_pkg::CLS_OP_IMM,
            rv_ctl_pkg::CLS_OP: begin
                case (funct3)
                    rv_ctl_pkg::F3_ADD_SUB: begin
                        if (is_op && funct7_b5) begin
                            alu_sel = rv_ctl_pkg::ALU_SUB;
                        end else begin
                            alu_sel = rv_ctl_pkg::ALU_ADD;
                        end
                    end
                    rv_ctl_pkg::F3_SLL:  alu_sel = rv_ctl_pkg::ALU_SLL;
                    rv_ctl_pkg::F3_SLT:  alu_sel = rv_ctl_pkg::ALU_SLT;
                    rv_ctl_pkg::F3_SLTU: alu_sel = rv_ctl_pkg::ALU_SLTU;
                    rv_ctl_pkg::F3_XOR:  alu_sel = rv_ctl_pkg::ALU_XOR;
                    // Arithmetic shift in both OP and OP-IMM
                    rv_ctl_pkg::F3_SRL_SRA: begin
                        if (funct7_b5) begin
                            alu_sel = rv_ctl_pkg::ALU_SRA;
                        end else begin
                            alu_sel = rv_ctl_pkg::ALU_SRL;
                        end
                    end
                    rv_ctl_pkg::F3_OR:   alu_sel = rv_ctl_pkg::ALU_OR;
                    rv_ctl_pkg::F3_AND:  alu_sel = rv_ctl_pkg::ALU_AND;
                    default:             alu_sel = rv_ctl_pkg::ALU_AND;
                endcase
            end
            default:                alu_sel = rv_ctl_pkg::ALU_AND;
        endcase

        assert (!(instr_class == rv_ctl_pkg::CLS_OP_IMM && alu_sel == rv_ctl_pkg::ALU_SUB))
            else $error("SUB decoded for OP-IMM, funct3 %b", funct3);
    end

endmodule

//--- verilog/branch_resolve.sv
`timescale 1ns/10ps

module branch_resolve (
    input  rv_ctl_pkg::instr_class_e instr_class,
    input  rv_ctl_pkg::funct3_t      funct3,
    input  logic                     br_eq,
    input  logic                     br_lt,
    output logic                     br_un,
    output logic                     pc_sel
);

    always_comb begin
        br_un  = 1'b0;
        pc_sel = 1'b0;

        case (instr_class)
            // Jumps always redirect
            rv_ctl_pkg::CLS_JAL,
            rv_ctl_pkg::CLS_JALR: begin
                pc_sel = 1'b1;
            end
            rv_ctl_pkg::CLS_BRANCH: begin
                case (funct3)
                    rv_ctl_pkg::F3_BEQ:  pc_sel = br_eq;
                    rv_ctl_pkg::F3_BNE:  pc_sel = ~br_eq;
                    rv_ctl_pkg::F3_BLT:  pc_sel = br_lt;
                    rv_ctl_pkg::F3_BGE:  pc_sel = ~br_lt;
                    // br_lt comes back as an unsigned result
                    rv_ctl_pkg::F3_BLTU: begin
                        br_un  = 1'b1;
                        pc_sel = br_lt;
                    end
                    rv_ctl_pkg::F3_BGEU: begin
                        br_un  = 1'b1;
                        pc_sel = ~br_lt;
                    end
                    default: begin
                        pc_sel = 1'b0;
                    end
                endcase
            end
            default: begin
                pc_sel = 1'b0;
            end
        endcase

        assert (!br_un || instr_class == rv_ctl_pkg::CLS_BRANCH)
            else $error("br_un set outside a branch, class %0d", instr_class);
    end

endmodule

//--- verilog/instr_ctl.sv
`timescale 1ns/10ps

module instr_ctl (
    input  rv_ctl_pkg::instr_t   instruction,
    input  logic                 br_eq,
    input  logic                 br_lt,
    output logic                 a_sel,
    output logic                 b_sel,
    output rv_ctl_pkg::alu_op_e  alu_sel,
    output rv_ctl_pkg::imm_sel_e imm_sel,
    output logic                 mem_wr,
    output logic                 reg_wen,
    output rv_ctl_pkg::wb_sel_e  wb_sel,
    output logic                 br_un,
    output logic                 pc_sel
);

    rv_ctl_pkg::opcode_t      opcode;
    rv_ctl_pkg::funct3_t      funct3;
    logic                     funct7_b5;
    rv_ctl_pkg::instr_class_e instr_class;

    // Instruction fields
    assign opcode    = instruction[6:0];
    assign funct3    = instruction[14:12];
    assign funct7_b5 = instruction[30];

    format_decode format_decode_inst (
        .opcode      (opcode),
        .instr_class (instr_class),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .imm_sel     (imm_sel),
        .mem_wr      (mem_wr),
        .reg_wen     (reg_wen),
        .wb_sel      (wb_sel)
    );

    alu_op_decode alu_op_decode_inst (
        .instr_class (instr_class),
        .funct3      (funct3),
        .funct7_b5   (funct7_b5),
        .alu_sel     (alu_sel)
    );

    branch_resolve branch_resolve_inst (
        .instr_class (instr_class),
        .funct3      (funct3),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .br_un       (br_un),
        .pc_sel      (pc_sel)
    );

endmodule

//--- tb/instr_ctl_ref.svh
// ALU code from the OP and OP-IMM funct3 table
function automatic logic [3:0] expected_alu(input logic [2:0] f3, input logic f7_b5,
                                            input logic is_op);
    case (f3)
        3'b000:  return (is_op && f7_b5) ? 4'b0100 : 4'b0011;
        3'b001:  return 4'b0111;
        3'b010:  return 4'b1100;
        3'b011:  return 4'b1011;
        3'b100:  return 4'b0010;
        3'b101:  return f7_b5 ? 4'b1010 : 4'b1000;
        3'b110:  return 4'b0001;
        default: return 4'b0000;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input logic eq, input logic lt);
    case (f3)
        3'b000:         return eq;
        3'b001:         return !eq;
        3'b100, 3'b110: return lt;
        3'b101, 3'b111: return !lt;
        default:        return 1'b0;
    endcase
endfunction

// Expected decoder outputs, packed as
// {a_sel, b_sel, alu_sel[3:0], imm_sel[3:0], mem_wr, reg_wen, wb_sel[1:0], br_un, pc_sel}
function automatic logic [15:0] expected_ctl(input logic [31:0] instr, input logic eq,
                                             input logic lt);
    logic [6:0] opc;
    logic [2:0] f3;
    logic       a;
    logic       b;
    logic       mw;
    logic       rw;
    logic       un;
    logic       pc;
    logic [3:0] alu;
    logic [3:0] imm;
    logic [1:0] wb;
    opc = instr[6:0];
    f3  = instr[14:12];
    un  = 1'b0;
    pc  = 1'b0;
    alu = 4'b0011;
    // Row order is a_sel, b_sel, imm_sel, reg_wen, wb_sel, mem_wr
    case (opc)
        7'b0110111: begin
            {a, b, imm, rw, wb, mw} = {1'b0, 1'b1, 4'd4, 1'b1, 2'd1, 1'b0};
            alu = 4'b0110;
        end
        7'b0010111: {a, b, imm, rw, wb, mw} = {1'b1, 1'b1, 4'd4, 1'b1, 2'd1, 1'b0};
        7'b1101111: begin
            {a, b, imm, rw, wb, mw} = {1'b1, 1'b1, 4'd5, 1'b1, 2'd2, 1'b0};
            pc = 1'b1;
        end
        7'b1100111: begin
            {a, b, imm, rw, wb, mw} = {1'b0, 1'b1, 4'd1, 1'b1, 2'd2, 1'b0};
            pc = 1'b1;
        end
        7'b1100011: begin
            {a, b, imm, rw, wb, mw} = {1'b1, 1'b1, 4'd3, 1'b0, 2'd0, 1'b0};
            // Unsigned compare for BLTU and BGEU only
            un = (f3[2:1] == 2'b11);
            pc = branch_taken(f3, eq, lt);
        end
        7'b0000011: {a, b, imm, rw, wb, mw} = {1'b0, 1'b1, 4'd1, 1'b1, 2'd0, 1'b0};
        7'b0100011: {a, b, imm, rw, wb, mw} = {1'b0, 1'b1, 4'd2, 1'b0, 2'd0, 1'b1};
        7'b0010011: begin
            {a, b, imm, rw, wb, mw} = {1'b0, 1'b1, 4'd1, 1'b1, 2'd1, 1'b0};
            alu = expected_alu(f3, instr[30], 1'b0);
        end
        7'b0110011: begin
            {a, b, imm, rw, wb, mw} = {1'b0, 1'b0, 4'd0, 1'b1, 2'd1, 1'b0};
            alu = expected_alu(f3, instr[30], 1'b1);
        end
        default: begin
            {a, b, imm, rw, wb, mw} = {1'b0, 1'b0, 4'd0, 1'b0, 2'd0, 1'b0};
            alu = 4'b0000;
        end
    endcase
    return {a, b, alu, imm, mw, rw, wb, un, pc};
endfunction

//--- tb/tb_instr_ctl.sv
`timescale 1ns/10ps

module tb_instr_ctl;

    logic                 clk;
    logic                 rst_n;
    rv_ctl_pkg::instr_t   instruction;
    logic                 br_eq;
    logic                 br_lt;
    logic                 a_sel;
    logic                 b_sel;
    rv_ctl_pkg::alu_op_e  alu_sel;
    rv_ctl_pkg::imm_sel_e imm_sel;
    logic                 mem_wr;
    logic                 reg_wen;
    rv_ctl_pkg::wb_sel_e  wb_sel;
    logic                 br_un;
    logic                 pc_sel;

    // Vectors are built before the first edge
    logic [31:0] vec_instr[$];
    logic [1:0]  vec_flags[$];
    string       vec_name[$];
    int          n_vec;
    logic        vectors_ready;
    logic        check_en;
    string       cur_name;
    int          check_count;
    int          error_count;

    `include "instr_ctl_ref.svh"

    instr_ctl instr_ctl_inst (
        .instruction (instruction),
        .br_eq       (br_eq),
        .br_lt       (br_lt),
        .a_sel       (a_sel),
        .b_sel       (b_sel),
        .alu_sel     (alu_sel),
        .imm_sel     (imm_sel),
        .mem_wr      (mem_wr),
        .reg_wen     (reg_wen),
        .wb_sel      (wb_sel),
        .br_un       (br_un),
        .pc_sel      (pc_sel)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

    // The eleven RV32I major opcodes
    function automatic logic [6:0] legal_opcode(input int k);
        case (k)
            0:       return 7'b0110111;
            1:       return 7'b0010111;
            2:       return 7'b1101111;
            3:       return 7'b1100111;
            4:       return 7'b1100011;
            5:       return 7'b0000011;
            6:       return 7'b0100011;
            7:       return 7'b0010011;
            8:       return 7'b0110011;
            9:       return 7'b0001111;
            default: return 7'b1110011;
        endcase
    endfunction

    function automatic logic is_known_opcode(input logic [6:0] opc);
        for (int k = 0; k < 11; k++) begin
            if (legal_opcode(k) == opc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic add_vec(input logic [31:0] instr, input logic [1:0] flags, input string name);
        vec_instr.push_back(instr);
        vec_flags.push_back(flags);
        vec_name.push_back(name);
    endtask

    task automatic build_vectors();
        logic [31:0] rnd;
        logic [31:0] fl_rnd;
        logic [6:0]  opc;
        add_vec({20'h12345, 5'd1, 7'b0110111}, 2'b00, "lui");
        add_vec({20'h00010, 5'd2, 7'b0010111}, 2'b00, "auipc");
        add_vec({20'h00100, 5'd1, 7'b1101111}, 2'b00, "jal");
        add_vec({12'h004, 5'd1, 3'd0, 5'd1, 7'b1100111}, 2'b00, "jalr");
        for (int f3 = 0; f3 < 6; f3++) begin
            if (f3 != 3) begin
                add_vec({12'h010, 5'd2, f3[2:0], 5'd3, 7'b0000011}, 2'b00, "load");
            end
        end
        for (int f3 = 0; f3 < 3; f3++) begin
            add_vec({7'd0, 5'd4, 5'd2, f3[2:0], 5'd8, 7'b0100011}, 2'b00, "store");
        end
        add_vec({4'h0, 4'hf, 4'hf, 5'd0, 3'd0, 5'd0, 7'b0001111}, 2'b00, "fence");
        add_vec(32'h0000_0073, 2'b00, "ecall");
        add_vec(32'h0010_0073, 2'b00, "ebreak");
        // ALU decode, both values of funct7 bit 5
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int b5 = 0; b5 < 2; b5++) begin
                add_vec({1'b0, b5[0], 5'd0, 5'd5, 5'd4, f3[2:0], 5'd6, 7'b0110011}, 2'b00,
                        "alu_op");
                add_vec({1'b0, b5[0], 10'h015, 5'd4, f3[2:0], 5'd6, 7'b0010011}, 2'b00,
                        "alu_op_imm");
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int fl = 0; fl < 4; fl++) begin
                add_vec({7'd0, 5'd2, 5'd1, f3[2:0], 5'd8, 7'b1100011}, fl[1:0], "branch");
            end
        end
        for (int fl = 0; fl < 4; fl++) begin
            add_vec({20'h00100, 5'd1, 7'b1101111}, fl[1:0], "jump_jal");
            add_vec({12'h004, 5'd1, 3'd0, 5'd1, 7'b1100111}, fl[1:0], "jump_jalr");
        end
        for (int i = 0; i < 50; i++) begin
            do begin
                rnd = $urandom();
            end while (is_known_opcode(rnd[6:0]));
            fl_rnd = $urandom();
            add_vec(rnd, fl_rnd[1:0], "unknown_opcode");
        end
        // Neither branches nor jumps, so pc_sel stays low
        for (int i = 0; i < 50; i++) begin
            do begin
                opc = legal_opcode($urandom_range(10, 0));
            end while (opc == 7'b1100011 || opc == 7'b1101111 || opc == 7'b1100111);
            rnd    = $urandom();
            fl_rnd = $urandom();
            add_vec({rnd[31:7], opc}, fl_rnd[1:0], "non_branch");
        end
        for (int i = 0; i < 2000; i++) begin
            rnd    = $urandom();
            fl_rnd = $urandom();
            add_vec({rnd[31:7], legal_opcode($urandom_range(10, 0))}, fl_rnd[1:0], "random");
        end
    endtask

    task automatic check_field(input string field, input logic [3:0] want, input logic [3:0] got);
        check_count++;
        assert (got === want) else begin
            error_count++;
            $display("Fail %s: %s expected %h, actual %h", cur_name, field, want, got);
        end
    endtask

    task automatic compare_outputs();
        logic [15:0] want;
        want = expected_ctl(instruction, br_eq, br_lt);
        check_field("a_sel", {3'b0, want[15]}, {3'b0, a_sel});
        check_field("b_sel", {3'b0, want[14]}, {3'b0, b_sel});
        check_field("alu_sel", want[13:10], alu_sel);
        check_field("imm_sel", want[9:6], imm_sel);
        check_field("mem_wr", {3'b0, want[5]}, {3'b0, mem_wr});
        check_field("reg_wen", {3'b0, want[4]}, {3'b0, reg_wen});
        check_field("wb_sel", {2'b0, want[3:2]}, {2'b0, wb_sel});
        check_field("br_un", {3'b0, want[1]}, {3'b0, br_un});
        check_field("pc_sel", {3'b0, want[0]}, {3'b0, pc_sel});
    endtask

    // Outputs are settled 1 ns after the edge that drove the inputs
    always @(posedge clk) begin
        #1;
        if (check_en) begin
            compare_outputs();
        end
    end

    initial begin
        void'($urandom(89));
        instruction   = '0;
        br_eq         = 1'b0;
        br_lt         = 1'b0;
        check_en      = 1'b0;
        check_count   = 0;
        error_count   = 0;
        vectors_ready = 1'b0;
        build_vectors();
        n_vec         = vec_instr.size();
        vectors_ready = 1'b1;
        wait (rst_n === 1'b1);
        for (int i = 0; i < n_vec; i++) begin
            @(posedge clk);
            instruction <= vec_instr[i];
            br_eq       <= vec_flags[i][1];
            br_lt       <= vec_flags[i][0];
            cur_name    <= vec_name[i];
            check_en    <= 1'b1;
        end
        @(posedge clk);
        check_en <= 1'b0;
        #2;
        $display("Summary: %0d vectors, %0d checks, %0d errors", n_vec, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // One clock per vector plus margin for reset
    initial begin
        wait (vectors_ready === 1'b1);
        #(n_vec * 8 + 200);
        $display("Error: watchdog expired before all vectors were checked");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- compile.f
+incdir+tb
verilog/rv_ctl_pkg.sv
verilog/format_decode.sv
verilog/alu_op_decode.sv
verilog/branch_resolve.sv
verilog/instr_ctl.sv
tb/tb_instr_ctl.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_instr_ctl
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -qxF "$(PASS_MSG)" $(LOG); then \
		echo "Result: simulation passed"; \
	else \
		echo "Result: simulation failed"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
